// ==== hdl/trace_mon_pkg.sv ====
`default_nettype none

package trace_mon_pkg;

  // Monitored cores and trace bus core index width
  localparam int NUM_CORES  = 3;
  localparam int CORE_IDX_W = 2;

  // Data, pc and instruction width
  localparam int XLEN = 32;

  // Register file addressing
  localparam int REG_ADDR_W = 5;

  // Register whose value is shadowed per core
  localparam logic [REG_ADDR_W-1:0] SHADOW_REG = 5'd3;

  // addi x0, x0, 1 ends the program on that core
  localparam logic [XLEN-1:0] INSN_TERMINATE = 32'h00100013;

  // addi x0, x0, 2 requests a report of x3
  localparam logic [XLEN-1:0] INSN_REPORT = 32'h00200013;

  // Event kinds
  localparam logic EVENT_REPORT    = 1'b0;
  localparam logic EVENT_TERMINATE = 1'b1;

endpackage

`default_nettype wire

// ==== hdl/trace_distributor.sv ====
`timescale 1ns/1ps
`default_nettype none

module trace_distributor (
  input  logic                                         clk,
  input  logic                                         arst_n_i,
  input  logic                                         trace_valid_i,
  input  logic [trace_mon_pkg::CORE_IDX_W-1:0]         trace_core_i,
  input  logic [trace_mon_pkg::XLEN-1:0]               trace_insn_i,
  input  logic                                         trace_wben_i,
  input  logic [trace_mon_pkg::REG_ADDR_W-1:0]         trace_wbreg_i,
  input  logic [trace_mon_pkg::XLEN-1:0]               trace_wbdata_i,
  output logic [trace_mon_pkg::NUM_CORES-1:0]          beat_valid_o,
  output logic [trace_mon_pkg::XLEN-1:0]               beat_insn_o,
  output logic                                         beat_wben_o,
  output logic [trace_mon_pkg::REG_ADDR_W-1:0]         beat_wbreg_o,
  output logic [trace_mon_pkg::XLEN-1:0]               beat_wbdata_o
);

  logic [trace_mon_pkg::NUM_CORES-1:0] strobe;

  // One-hot decode, an out of range index matches no core
  always_comb begin
    for (int c = 0; c < trace_mon_pkg::NUM_CORES; c++) begin
      strobe[c] = trace_valid_i &&
                  (trace_core_i == trace_mon_pkg::CORE_IDX_W'(c));
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_valid_o <= '0;
    end else begin
      beat_valid_o <= strobe;
    end
  end

  // Beat fields are shared by all monitors
  always_ff @(posedge clk) begin
    beat_insn_o   <= trace_insn_i;
    beat_wben_o   <= trace_wben_i;
    beat_wbreg_o  <= trace_wbreg_i;
    beat_wbdata_o <= trace_wbdata_i;
  end

endmodule

`default_nettype wire

// ==== hdl/core_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_monitor (
  input  logic                                 clk,
  input  logic                                 arst_n_i,
  input  logic                                 beat_valid_i,
  input  logic [trace_mon_pkg::XLEN-1:0]       beat_insn_i,
  input  logic                                 beat_wben_i,
  input  logic [trace_mon_pkg::REG_ADDR_W-1:0] beat_wbreg_i,
  input  logic [trace_mon_pkg::XLEN-1:0]       beat_wbdata_i,
  output logic                                 evt_valid_o,
  output logic                                 evt_kind_o,
  output logic [trace_mon_pkg::XLEN-1:0]       evt_value_o,
  output logic                                 terminated_o
);

  logic [trace_mon_pkg::XLEN-1:0] shadow_x3;
  logic [trace_mon_pkg::XLEN-1:0] retired_cnt;
  logic [trace_mon_pkg::XLEN-1:0] retired_nxt;
  logic                           beat_live;
  logic                           is_report;
  logic                           is_terminate;
  logic                           x3_write;

  // Beats to a frozen core are dropped entirely
  assign beat_live    = beat_valid_i && !terminated_o;
  assign retired_nxt  = retired_cnt + 1'b1;

  assign is_report    = (beat_insn_i == trace_mon_pkg::INSN_REPORT);
  assign is_terminate = (beat_insn_i == trace_mon_pkg::INSN_TERMINATE);

  // x0 never matches the shadowed register, so x0 writes fall out here
  assign x3_write = beat_wben_i && (beat_wbreg_i == trace_mon_pkg::SHADOW_REG);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      shadow_x3    <= '0;
      retired_cnt  <= '0;
      terminated_o <= 1'b0;
      evt_valid_o  <= 1'b0;
    end else begin
      evt_valid_o <= 1'b0;
      if (beat_live) begin
        retired_cnt <= retired_nxt;
        if (x3_write) begin
          shadow_x3 <= beat_wbdata_i;
        end
        if (is_report || is_terminate) begin
          evt_valid_o <= 1'b1;
        end
        if (is_terminate) begin
          terminated_o <= 1'b1;
        end
      end
    end
  end

  // Event payload, qualified by evt_valid_o downstream
  always_ff @(posedge clk) begin
    if (beat_live && is_terminate) begin
      evt_kind_o  <= trace_mon_pkg::EVENT_TERMINATE;
      // Count includes the marker itself
      evt_value_o <= retired_nxt;
    end else if (beat_live && is_report) begin
      evt_kind_o  <= trace_mon_pkg::EVENT_REPORT;
      // Value before this beat, the marker writes nothing
      evt_value_o <= shadow_x3;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/event_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module event_collector (
  input  logic                                 clk,
  input  logic                                 arst_n_i,
  input  logic [trace_mon_pkg::NUM_CORES-1:0]  evt_valid_i,
  input  logic [trace_mon_pkg::NUM_CORES-1:0]  evt_kind_i,
  input  logic [trace_mon_pkg::XLEN-1:0]       evt_value_i [trace_mon_pkg::NUM_CORES],
  input  logic [trace_mon_pkg::NUM_CORES-1:0]  terminated_i,
  output logic                                 event_valid_o,
  output logic                                 event_kind_o,
  output logic [trace_mon_pkg::CORE_IDX_W-1:0] event_core_o,
  output logic [trace_mon_pkg::XLEN-1:0]       event_value_o,
  output logic                                 all_done_o
);

  logic                                 sel_kind;
  logic [trace_mon_pkg::CORE_IDX_W-1:0] sel_core;
  logic [trace_mon_pkg::XLEN-1:0]       sel_value;

  // At most one monitor fires per cycle, so an AND-OR mux is enough
  always_comb begin
    sel_kind  = 1'b0;
    sel_core  = '0;
    sel_value = '0;
    for (int c = 0; c < trace_mon_pkg::NUM_CORES; c++) begin
      if (evt_valid_i[c]) begin
        sel_kind  = sel_kind | evt_kind_i[c];
        sel_core  = sel_core | trace_mon_pkg::CORE_IDX_W'(c);
        sel_value = sel_value | evt_value_i[c];
      end
    end
  end

  // terminated rises with evt_valid, so both line up one cycle later
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      event_valid_o <= 1'b0;
      all_done_o    <= 1'b0;
    end else begin
      event_valid_o <= |evt_valid_i;
      all_done_o    <= &terminated_i;
    end
  end

  always_ff @(posedge clk) begin
    if (|evt_valid_i) begin
      event_kind_o  <= sel_kind;
      event_core_o  <= sel_core;
      event_value_o <= sel_value;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/trace_mon_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module trace_mon_top (
  input  logic                                 clk,
  input  logic                                 arst_n_i,
  input  logic                                 trace_valid_i,
  input  logic [trace_mon_pkg::CORE_IDX_W-1:0] trace_core_i,
  input  logic [trace_mon_pkg::XLEN-1:0]       trace_pc_i,
  input  logic [trace_mon_pkg::XLEN-1:0]       trace_insn_i,
  input  logic                                 trace_wben_i,
  input  logic [trace_mon_pkg::REG_ADDR_W-1:0] trace_wbreg_i,
  input  logic [trace_mon_pkg::XLEN-1:0]       trace_wbdata_i,
  output logic                                 event_valid_o,
  output logic                                 event_kind_o,
  output logic [trace_mon_pkg::CORE_IDX_W-1:0] event_core_o,
  output logic [trace_mon_pkg::XLEN-1:0]       event_value_o,
  output logic                                 all_done_o
);

  // Registered beat, shared by all monitors
  logic [trace_mon_pkg::NUM_CORES-1:0]  beat_valid;
  logic [trace_mon_pkg::XLEN-1:0]       beat_insn;
  logic                                 beat_wben;
  logic [trace_mon_pkg::REG_ADDR_W-1:0] beat_wbreg;
  logic [trace_mon_pkg::XLEN-1:0]       beat_wbdata;

  // Per-core events and state
  logic [trace_mon_pkg::NUM_CORES-1:0]  evt_valid;
  logic [trace_mon_pkg::NUM_CORES-1:0]  evt_kind;
  logic [trace_mon_pkg::XLEN-1:0]       evt_value [trace_mon_pkg::NUM_CORES];
  logic [trace_mon_pkg::NUM_CORES-1:0]  terminated;

  // trace_pc_i is kept on the port list but not needed by any check
  trace_distributor i_distributor (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .trace_valid_i  (trace_valid_i),
    .trace_core_i   (trace_core_i),
    .trace_insn_i   (trace_insn_i),
    .trace_wben_i   (trace_wben_i),
    .trace_wbreg_i  (trace_wbreg_i),
    .trace_wbdata_i (trace_wbdata_i),
    .beat_valid_o   (beat_valid),
    .beat_insn_o    (beat_insn),
    .beat_wben_o    (beat_wben),
    .beat_wbreg_o   (beat_wbreg),
    .beat_wbdata_o  (beat_wbdata)
  );

  for (genvar g = 0; g < trace_mon_pkg::NUM_CORES; g++) begin : gen_core
    core_monitor i_monitor (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .beat_valid_i  (beat_valid[g]),
      .beat_insn_i   (beat_insn),
      .beat_wben_i   (beat_wben),
      .beat_wbreg_i  (beat_wbreg),
      .beat_wbdata_i (beat_wbdata),
      .evt_valid_o   (evt_valid[g]),
      .evt_kind_o    (evt_kind[g]),
      .evt_value_o   (evt_value[g]),
      .terminated_o  (terminated[g])
    );
  end

  event_collector i_collector (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .evt_valid_i   (evt_valid),
    .evt_kind_i    (evt_kind),
    .evt_value_i   (evt_value),
    .terminated_i  (terminated),
    .event_valid_o (event_valid_o),
    .event_kind_o  (event_kind_o),
    .event_core_o  (event_core_o),
    .event_value_o (event_value_o),
    .all_done_o    (all_done_o)
  );

endmodule

`default_nettype wire

// ==== verification/trace_mon_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module trace_mon_properties (
  input logic                                 clk,
  input logic                                 arst_n_i,
  input logic                                 event_valid_i,
  input logic [trace_mon_pkg::CORE_IDX_W-1:0] event_core_i,
  input logic                                 all_done_i
);

  // Read by the testbench when it closes the run
  int unsigned fail_count = 0;

  a_quiet_in_reset: assert property (@(posedge clk) !arst_n_i |-> !event_valid_i)
    else begin
      $error("event_valid_o high while reset is asserted");
      fail_count = fail_count + 1;
    end

  // Completion is sticky until the next reset
  a_done_sticky: assert property (@(posedge clk) disable iff (!arst_n_i)
    all_done_i |=> all_done_i)
    else begin
      $error("all_done_o fell without a reset");
      fail_count = fail_count + 1;
    end

  a_core_in_range: assert property (@(posedge clk) disable iff (!arst_n_i)
    event_valid_i |-> (event_core_i < trace_mon_pkg::CORE_IDX_W'(trace_mon_pkg::NUM_CORES)))
    else begin
      $error("event_core_o out of range with event_valid_o high");
      fail_count = fail_count + 1;
    end

endmodule

bind trace_mon_top trace_mon_properties i_properties (
  .clk           (clk),
  .arst_n_i      (arst_n_i),
  .event_valid_i (event_valid_o),
  .event_core_i  (event_core_o),
  .all_done_i    (all_done_o)
);

`default_nettype wire

// ==== verification/trace_mon_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module trace_mon_tb;

  logic                                 clk;
  logic                                 arst_n;
  logic                                 trace_valid;
  logic [trace_mon_pkg::CORE_IDX_W-1:0] trace_core;
  logic [trace_mon_pkg::XLEN-1:0]       trace_pc;
  logic [trace_mon_pkg::XLEN-1:0]       trace_insn;
  logic                                 trace_wben;
  logic [trace_mon_pkg::REG_ADDR_W-1:0] trace_wbreg;
  logic [trace_mon_pkg::XLEN-1:0]       trace_wbdata;
  logic                                 event_valid;
  logic                                 event_kind;
  logic [trace_mon_pkg::CORE_IDX_W-1:0] event_core;
  logic [trace_mon_pkg::XLEN-1:0]       event_value;
  logic                                 all_done;

  // Beats and expected events from the data file
  logic [31:0] t_core [$];
  logic [31:0] t_insn [$];
  logic [31:0] t_wben [$];
  logic [31:0] t_wbreg [$];
  logic [31:0] t_wbdata [$];
  logic [31:0] e_kind [$];
  logic [31:0] e_core [$];
  logic [31:0] e_value [$];
  logic        d_done;

  logic [31:0] lfsr;
  logic [1:0]  gap;
  logic        loaded;
  int          drain;
  int          ev_idx;
  int          term_seen;
  int          term_total;
  int          mismatch_errors;
  int          extra_errors;
  int          missing_errors;
  int          other_errors;

  trace_mon_top i_dut (
    .clk            (clk),
    .arst_n_i       (arst_n),
    .trace_valid_i  (trace_valid),
    .trace_core_i   (trace_core),
    .trace_pc_i     (trace_pc),
    .trace_insn_i   (trace_insn),
    .trace_wben_i   (trace_wben),
    .trace_wbreg_i  (trace_wbreg),
    .trace_wbdata_i (trace_wbdata),
    .event_valid_o  (event_valid),
    .event_kind_o   (event_kind),
    .event_core_o   (event_core),
    .event_value_o  (event_value),
    .all_done_o     (all_done)
  );

  always #50 clk = ~clk;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  task automatic draw_gap(output logic [1:0] g);
    g[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    g[1] = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    string       rest;
    logic [31:0] f0, f1, f2, f3, f4;
    fd = $fopen("verification/trace_mon_stimulus.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open the stimulus file");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1) begin
        rest = line.substr(1, line.len() - 1);
        if (line[0] == "T") begin
          n = $sscanf(rest, "%h %h %h %h %h", f0, f1, f2, f3, f4);
          if (n == 5) begin
            t_core.push_back(f0);
            t_insn.push_back(f1);
            t_wben.push_back(f2);
            t_wbreg.push_back(f3);
            t_wbdata.push_back(f4);
          end else begin
            other_errors++;
            $display("Malformed trace record in the stimulus file: %s", line);
          end
        end else if (line[0] == "E") begin
          n = $sscanf(rest, "%h %h %h", f0, f1, f2);
          if (n == 3) begin
            e_kind.push_back(f0);
            e_core.push_back(f1);
            e_value.push_back(f2);
            if (f0[0]) begin
              term_total++;
            end
          end else begin
            other_errors++;
            $display("Malformed event record in the stimulus file: %s", line);
          end
        end else if (line[0] == "D") begin
          n = $sscanf(rest, "%h", f0);
          d_done = f0[0];
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_beat(input int i);
    trace_valid  = 1'b1;
    trace_core   = t_core[i][trace_mon_pkg::CORE_IDX_W-1:0];
    trace_pc     = 32'h0000_1000 + 32'(i * 4);
    trace_insn   = t_insn[i];
    trace_wben   = t_wben[i][0];
    trace_wbreg  = t_wbreg[i][trace_mon_pkg::REG_ADDR_W-1:0];
    trace_wbdata = t_wbdata[i];
  endtask

  task automatic report_and_finish();
    int total;
    total = mismatch_errors + extra_errors + missing_errors + other_errors
            + int'(i_dut.i_properties.fail_count);
    $display("Errors: %0d mismatch, %0d unexpected, %0d missing, %0d assertion, %0d other",
             mismatch_errors, extra_errors, missing_errors,
             i_dut.i_properties.fail_count, other_errors);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // Outputs settle after the rising edge, so check on the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      if (event_valid === 1'b1) begin
        if (ev_idx >= e_kind.size()) begin
          extra_errors++;
          $display("Unexpected event at %0t from core %0d, no more events were expected",
                   $time, event_core);
        end else begin
          if (event_kind !== e_kind[ev_idx][0]) begin
            mismatch_errors++;
            $display("FAIL %0t event %0d kind %0d, expected %0d",
                     $time, ev_idx, event_kind, e_kind[ev_idx][0]);
          end
          if (event_core !== e_core[ev_idx][trace_mon_pkg::CORE_IDX_W-1:0]) begin
            mismatch_errors++;
            $display("FAIL %0t event %0d core %0d, expected %0d",
                     $time, ev_idx, event_core, e_core[ev_idx]);
          end
          if (event_value !== e_value[ev_idx]) begin
            mismatch_errors++;
            $display("FAIL %0t event %0d value %h, expected %h",
                     $time, ev_idx, event_value, e_value[ev_idx]);
          end
          if (e_kind[ev_idx][0]) begin
            term_seen++;
          end
          ev_idx++;
        end
      end
      // Done only once the last expected terminate event has come out
      if (term_seen < term_total) begin
        if (all_done !== 1'b0) begin
          mismatch_errors++;
          $display("FAIL %0t all_done_o high while a core is still running", $time);
        end
      end else if (all_done !== d_done) begin
        mismatch_errors++;
        $display("FAIL %0t all_done_o %b, expected %b", $time, all_done, d_done);
      end
    end
  end

  initial begin
    wait (loaded === 1'b1);
    repeat (t_core.size() * 4 + 50) @(posedge clk);
    other_errors++;
    $display("Timeout, the run did not complete within the cycle budget");
    report_and_finish();
  end

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    trace_valid  = 1'b0;
    trace_core   = '0;
    trace_pc     = '0;
    trace_insn   = '0;
    trace_wben   = 1'b0;
    trace_wbreg  = '0;
    trace_wbdata = '0;
    d_done       = 1'b0;
    loaded       = 1'b0;
    lfsr         = 32'h6b583ba3;
    load_stimulus();
    loaded = 1'b1;
    if (other_errors == 0) begin
      repeat (8) @(posedge clk);
      #10;
      arst_n = 1'b1;
      for (int i = 0; i < t_core.size(); i++) begin
        @(posedge clk);
        #10;
        apply_beat(i);
        draw_gap(gap);
        repeat (gap) begin
          @(posedge clk);
          #10;
          trace_valid = 1'b0;
        end
      end
      @(posedge clk);
      #10;
      trace_valid = 1'b0;
      // Wait for the outstanding events, bounded by the pipeline depth
      drain = 0;
      while (ev_idx < e_kind.size() && drain < 8) begin
        @(posedge clk);
        drain++;
      end
      repeat (4) @(posedge clk);
      if (ev_idx < e_kind.size()) begin
        missing_errors = missing_errors + e_kind.size() - ev_idx;
        $display("Missing events, only %0d of %0d expected events appeared",
                 ev_idx, e_kind.size());
      end
    end
    report_and_finish();
  end

endmodule

`default_nettype wire

// ==== verification/trace_mon_stimulus.txt ====
# T core insn wben wbreg wbdata gives one trace beat, all fields hex
# E kind core value gives one expected event (kind 0 report, 1 terminate), D gives final all_done
T 0 00500193 1 03 0000abcd
T 1 00700193 1 03 12345678
T 0 00200013 0 00 00000000
E 0 0 0000abcd
T 0 00000093 1 00 deadbeef
T 0 00100213 1 04 55555555
T 0 00200013 0 00 00000000
E 0 0 0000abcd
T 3 00200013 0 00 00000000
T 3 00100013 1 03 99999999
T 2 00000013 0 00 00000000
T 2 00200013 0 00 00000000
E 0 2 00000000
T 1 00200013 0 00 00000000
E 0 1 12345678
T 2 00900193 1 03 00000042
T 1 00100013 0 00 00000000
E 1 1 00000003
T 1 00200013 1 03 ffffffff
T 1 00100013 0 00 00000000
T 0 00100013 0 00 00000000
E 1 0 00000006
T 2 00200013 0 00 00000000
E 0 2 00000042
T 3 00000013 0 00 00000000
T 2 00100013 0 00 00000000
E 1 2 00000005
D 1

// ==== trace_mon.f ====
hdl/trace_mon_pkg.sv
hdl/trace_distributor.sv
hdl/core_monitor.sv
hdl/event_collector.sv
hdl/trace_mon_top.sv
verification/trace_mon_properties.sv
verification/trace_mon_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the trace monitor testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module trace_mon_tb -f trace_mon.f --Mdir obj_dir -o Vtrace_mon_tb
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

./obj_dir/Vtrace_mon_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  echo "Testbench reported failure"
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
